// ==== Makefile ====
# Verilator build and run of the SoC harness testbench
TOP := soc_harness_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -o tb_sim
	./obj_dir/tb_sim | awk '{ print } /^NO ERRORS$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

// ==== boot_rom.hex ====
// one 32-bit boot image word per line, word 0 first
00000297
02028293
30529073
00000513
00100593
00b50633
80000737
00c72023
00472683
0ff00793
00f6a023
10500073
0000006f
deadbeef
cafef00d
13579bdf

// ==== boot_rom.sv ====
// image comes from boot_rom.hex in the run directory, one hex word per line, at time zero
`timescale 1ns/100ps
`include "soc_params.svh"

module boot_rom import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     req_i,
  input  rom_idx_t idx_i,
  output data_t    rdata_o
);

  data_t mem [`SOC_ROM_WORDS];

  initial begin
    $readmemh("boot_rom.hex", mem);
  end

  // one cycle read latency, output holds between reads
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

// ==== bus_router.sv ====
// no back-pressure; every request gets its response exactly one cycle later, in order
`timescale 1ns/100ps
`include "soc_params.svh"

module bus_router import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o,
  // boot rom
  output logic     rom_req_o,
  output rom_idx_t rom_idx_o,
  input  data_t    rom_rdata_i,
  // main ram
  output logic     ram_req_o,
  output logic     ram_we_o,
  output ram_idx_t ram_idx_o,
  output be_t      ram_be_o,
  output data_t    ram_wdata_o,
  input  data_t    ram_rdata_i,
  // debug unit
  output logic     dbg_req_o,
  output logic     dbg_we_o,
  output dbg_reg_e dbg_sel_o,
  output data_t    dbg_wdata_o,
  input  data_t    dbg_rdata_i
);

  // unsigned wrap makes addresses below base fail the compare too
  function automatic logic in_region(addr_t addr, addr_t base, addr_t len);
    return (addr - base) < len;
  endfunction

  region_e region;
  logic    req_err;
  logic    valid_q;
  logic    we_q;
  logic    err_q;
  region_e region_q;

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------
  always_comb begin
    if (in_region(req_i.addr, `SOC_DEBUG_BASE, `SOC_DEBUG_LEN)) begin
      region = REGION_DEBUG;
    end else if (in_region(req_i.addr, `SOC_ROM_BASE, `SOC_ROM_LEN)) begin
      region = REGION_ROM;
    end else if (in_region(req_i.addr, `SOC_RAM_BASE, `SOC_RAM_LEN)) begin
      region = REGION_RAM;
    end else begin
      region = REGION_NONE;
    end
  end

  // unmapped or rom write
  assign req_err = req_i.valid &
                   ((region == REGION_NONE) | ((region == REGION_ROM) & req_i.we));

  // strobes go to the decoded target only
  assign rom_req_o = req_i.valid & (region == REGION_ROM) & ~req_i.we;
  assign ram_req_o = req_i.valid & (region == REGION_RAM);
  assign dbg_req_o = req_i.valid & (region == REGION_DEBUG);

  assign rom_idx_o   = req_i.addr[$bits(rom_idx_t)+1:2];
  assign ram_we_o    = req_i.we;
  assign ram_idx_o   = req_i.addr[$bits(ram_idx_t)+1:2];
  assign ram_be_o    = req_i.be;
  assign ram_wdata_o = req_i.wdata;
  assign dbg_we_o    = req_i.we;
  assign dbg_sel_o   = dbg_reg_e'(req_i.addr[3:2]);
  assign dbg_wdata_o = req_i.wdata;

  // --------------------------------------------------
  // response
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      err_q    <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      valid_q  <= req_i.valid;
      we_q     <= req_i.we;
      err_q    <= req_err;
      region_q <= region;
    end
  end

  always_comb begin
    rsp_o       = '0;
    rsp_o.valid = valid_q;
    rsp_o.err   = err_q;
    // writes and errors return zero data
    if (valid_q && !we_q && !err_q) begin
      case (region_q)
        REGION_ROM:   rsp_o.rdata = rom_rdata_i;
        REGION_RAM:   rsp_o.rdata = ram_rdata_i;
        REGION_DEBUG: rsp_o.rdata = dbg_rdata_i;
        default:      rsp_o.rdata = '0;
      endcase
    end
  end

endmodule

// ==== debug_unit.sv ====
// register offsets alias every 16 bytes in the debug region; byte enables are ignored
`timescale 1ns/100ps
`include "soc_params.svh"

module debug_unit import soc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  dbg_reg_e    sel_i,
  input  data_t       wdata_i,
  input  logic        debug_en_i,
  output data_t       rdata_o,
  output logic        debug_req_o,
  output logic [31:0] exit_o
);

  localparam int unsigned holdoff_w = $clog2(`SOC_DBG_HOLDOFF + 1);

  logic                 halt_q;
  data_t                exit_q;
  logic [holdoff_w-1:0] holdoff_q;
  logic                 holdoff_active;
  logic                 debug_req_q;

  assign holdoff_active = (holdoff_q != '0);

  // --------------------------------------------------
  // control registers and hold-off
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halt_q      <= 1'b0;
      exit_q      <= '0;
      holdoff_q   <= holdoff_w'(`SOC_DBG_HOLDOFF);
      debug_req_q <= 1'b0;
    end else begin
      if (holdoff_active) begin
        holdoff_q <= holdoff_q - 1'b1;
      end
      if (req_i && we_i) begin
        case (sel_i)
          DBG_CTRL: halt_q <= wdata_i[0];
          DBG_EXIT: exit_q <= wdata_i;
          default:  ;
        endcase
      end
      // the core only sees a halt once boot code had time to run
      debug_req_q <= halt_q & debug_en_i & ~holdoff_active;
    end
  end

  // read data, sampled before any same-cycle write
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (sel_i)
        DBG_CTRL:   rdata_o <= data_t'(halt_q);
        DBG_EXIT:   rdata_o <= exit_q;
        DBG_STATUS: rdata_o <= data_t'(holdoff_active);
        default:    rdata_o <= '0;
      endcase
    end
  end

  assign debug_req_o = debug_req_q;
  assign exit_o      = exit_q;

endmodule

// ==== main_sram.sv ====
// contents are undefined until written; a read returns the word as it was before the edge
`timescale 1ns/100ps
`include "soc_params.svh"

module main_sram import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     req_i,
  input  logic     we_i,
  input  ram_idx_t idx_i,
  input  be_t      be_i,
  input  data_t    wdata_i,
  output data_t    rdata_o
);

  data_t mem [`SOC_RAM_WORDS];

  // byte lanes follow be_i on writes
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < $bits(be_t); b++) begin
          if (be_i[b]) begin
            mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[idx_i];
      end
    end
  end

endmodule

// ==== soc_harness.sv ====
// master must take each response in the cycle after its request; there is no stall path
`timescale 1ns/100ps

module soc_harness import soc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  mem_req_t    bus_req_i,
  input  logic        debug_en_i,
  output mem_rsp_t    bus_rsp_o,
  output logic        debug_req_o,
  output logic [31:0] exit_o
);

  logic     rom_req;
  rom_idx_t rom_idx;
  data_t    rom_rdata;

  logic     ram_req;
  logic     ram_we;
  ram_idx_t ram_idx;
  be_t      ram_be;
  data_t    ram_wdata;
  data_t    ram_rdata;

  logic     dbg_req;
  logic     dbg_we;
  dbg_reg_e dbg_sel;
  data_t    dbg_wdata;
  data_t    dbg_rdata;

  bus_router i_bus_router (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .req_i       ( bus_req_i ),
    .rsp_o       ( bus_rsp_o ),
    .rom_req_o   ( rom_req   ),
    .rom_idx_o   ( rom_idx   ),
    .rom_rdata_i ( rom_rdata ),
    .ram_req_o   ( ram_req   ),
    .ram_we_o    ( ram_we    ),
    .ram_idx_o   ( ram_idx   ),
    .ram_be_o    ( ram_be    ),
    .ram_wdata_o ( ram_wdata ),
    .ram_rdata_i ( ram_rdata ),
    .dbg_req_o   ( dbg_req   ),
    .dbg_we_o    ( dbg_we    ),
    .dbg_sel_o   ( dbg_sel   ),
    .dbg_wdata_o ( dbg_wdata ),
    .dbg_rdata_i ( dbg_rdata )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  main_sram i_main_sram (
    .clk_i   ( clk_i     ),
    .req_i   ( ram_req   ),
    .we_i    ( ram_we    ),
    .idx_i   ( ram_idx   ),
    .be_i    ( ram_be    ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

  debug_unit i_debug_unit (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_i       ( dbg_req     ),
    .we_i        ( dbg_we      ),
    .sel_i       ( dbg_sel     ),
    .wdata_i     ( dbg_wdata   ),
    .debug_en_i  ( debug_en_i  ),
    .rdata_o     ( dbg_rdata   ),
    .debug_req_o ( debug_req_o ),
    .exit_o      ( exit_o      )
  );

endmodule

// ==== soc_harness_chk.sv ====
// bound into soc_harness; the hold-off state comes from the debug unit instance by name
`timescale 1ns/100ps

module soc_harness_chk import soc_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input mem_req_t req_i,
  input mem_rsp_t rsp_i,
  input logic     debug_req_i,
  input logic     holdoff_active_i
);

  // one response per request, exactly one cycle later
  rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.valid |=> rsp_i.valid)
    else $error("request without a response in the next cycle");

  rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.valid |-> $past(req_i.valid))
    else $error("response without a request in the previous cycle");

  err_zero_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_i.valid && rsp_i.err) |-> (rsp_i.rdata == '0))
    else $error("error response carries nonzero read data");

  no_debug_in_holdoff: assert property (@(posedge clk_i) disable iff (!rst_ni)
    holdoff_active_i |-> !debug_req_i)
    else $error("debug request high during hold-off");

endmodule

bind soc_harness soc_harness_chk chk0 (
  .clk_i            ( clk_i                       ),
  .rst_ni           ( rst_ni                      ),
  .req_i            ( bus_req_i                   ),
  .rsp_i            ( bus_rsp_o                   ),
  .debug_req_i      ( debug_req_o                 ),
  .holdoff_active_i ( i_debug_unit.holdoff_active )
);

// ==== soc_harness_tb.sv ====
// run from the project root so boot_rom.hex resolves; ram words are read only after a write
`timescale 1ns/100ps
`include "soc_params.svh"

module soc_harness_tb import soc_pkg::*; ();

  localparam int unsigned clk_period = 100;
  localparam int unsigned n_ram_init = 32;
  localparam int unsigned n_ram_rand = 48;
  localparam int unsigned n_unmapped = 6;
  localparam int unsigned run_cycles = 4 + (`SOC_DBG_HOLDOFF + 20) + (`SOC_ROM_WORDS + 4)
                                       + (2 * n_ram_init + n_ram_rand) + 2 * n_unmapped + 10;
  localparam int unsigned watchdog_cycles = 2 * run_cycles + 100;

  localparam addr_t unmapped_addrs [n_unmapped] = '{
    32'h0000_0100, 32'h0000_fffc, 32'h0001_0040,
    32'h4000_0000, 32'h8000_0400, 32'hffff_fffc
  };

  logic        clk_i;
  logic        rst_ni;
  mem_req_t    bus_req;
  logic        debug_en;
  mem_rsp_t    bus_rsp;
  logic        debug_req;
  logic [31:0] exit_code;

  // reference model state
  data_t       rom_image [`SOC_ROM_WORDS];
  data_t       model_ram [`SOC_RAM_WORDS];
  logic        model_halt;
  data_t       model_exit;
  logic [31:0] rng_state;
  int unsigned cyc;
  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned test_err_base;
  string       cur_test;

  soc_harness dut0 (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .bus_req_i   ( bus_req   ),
    .debug_en_i  ( debug_en  ),
    .bus_rsp_o   ( bus_rsp   ),
    .debug_req_o ( debug_req ),
    .exit_o      ( exit_code )
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic addr_hits(addr_t addr, addr_t base, addr_t len);
    return (addr >= base) && (addr < base + len);
  endfunction

  // ram slots are spread over the whole array
  function automatic addr_t ram_slot_addr(int unsigned slot, logic [1:0] low);
    return `SOC_RAM_BASE + addr_t'((8 * slot + 5) * 4) + addr_t'(low);
  endfunction

  // expected response for one request, updating the model state
  function automatic mem_rsp_t ref_access(mem_req_t req, int unsigned edges);
    mem_rsp_t    rsp;
    int unsigned idx;
    rsp = '0;
    if (req.valid) begin
      rsp.valid = 1'b1;
      if (addr_hits(req.addr, `SOC_RAM_BASE, `SOC_RAM_LEN)) begin
        idx = (req.addr - `SOC_RAM_BASE) >> 2;
        if (req.we) begin
          for (int b = 0; b < `SOC_BE_W; b++) begin
            if (req.be[b]) begin
              model_ram[idx][8*b +: 8] = req.wdata[8*b +: 8];
            end
          end
        end else begin
          rsp.rdata = model_ram[idx];
        end
      end else if (addr_hits(req.addr, `SOC_ROM_BASE, `SOC_ROM_LEN)) begin
        if (req.we) begin
          rsp.err = 1'b1;
        end else begin
          rsp.rdata = rom_image[(req.addr - `SOC_ROM_BASE) >> 2];
        end
      end else if (addr_hits(req.addr, `SOC_DEBUG_BASE, `SOC_DEBUG_LEN)) begin
        idx = ((req.addr - `SOC_DEBUG_BASE) >> 2) % 4;
        if (req.we) begin
          if (idx == 0) model_halt = req.wdata[0];
          if (idx == 1) model_exit = req.wdata;
        end else begin
          case (idx)
            0:       rsp.rdata = data_t'(model_halt);
            1:       rsp.rdata = model_exit;
            2:       rsp.rdata = data_t'(edges < `SOC_DBG_HOLDOFF);
            default: rsp.rdata = '0;
          endcase
        end
      end else begin
        rsp.err = 1'b1;
      end
    end
    return rsp;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("** Error [%s] %s: expected %0h, actual %0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("** Failure [%s] %s", cur_test, msg);
  endtask

  task automatic issue(input logic we, input addr_t addr, input be_t be, input data_t wdata);
    mem_req_t req;
    req.valid = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.be    = be;
    req.wdata = wdata;
    @(posedge clk_i);
    bus_req <= req;
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      bus_req <= '0;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    test_err_base = errors;
  endtask

  // lets the last response drain before the verdict
  task automatic finish_test();
    idle(2);
    tests_run++;
    if (errors == test_err_base) begin
      $display("test %s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", cur_test, errors - test_err_base);
    end
  endtask

  // --------------------------------------------------
  // clock, edge count, compare, watchdog
  // --------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // edges since reset release
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cyc <= cyc + 1;
    end
  end

  // request seen at one negedge is answered at the next
  initial begin : compare_responses
    mem_rsp_t pending;
    logic     dbg_req_exp;
    pending     = '0;
    dbg_req_exp = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        check_value("bus response", pending, bus_rsp);
        check_value("exit_o", model_exit, exit_code);
        check_value("debug_req_o", dbg_req_exp, debug_req);
        dbg_req_exp = model_halt && debug_en && (cyc >= `SOC_DBG_HOLDOFF);
        pending     = ref_access(bus_req, cyc);
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("** Failure: run did not finish within %0d cycles", watchdog_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin : main_sequence
    int unsigned waited;
    logic [31:0] r;
    rst_ni        = 1'b0;
    bus_req       = '0;
    debug_en      = 1'b0;
    model_halt    = 1'b0;
    model_exit    = '0;
    rng_state     = 32'd97345;
    cyc           = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    cur_test      = "reset";
    $readmemh("boot_rom.hex", rom_image);
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    begin_test("debug_exit_status");
    issue(1'b0, `SOC_DEBUG_BASE + 32'h8, '0, '0);
    issue(1'b1, `SOC_DEBUG_BASE + 32'h4, 4'hf, next_random());
    issue(1'b0, `SOC_DEBUG_BASE + 32'h4, '0, '0);
    finish_test();

    begin_test("debug_request");
    debug_en <= 1'b1;
    issue(1'b1, `SOC_DEBUG_BASE, 4'hf, 32'h1);
    issue(1'b0, `SOC_DEBUG_BASE, '0, '0);
    idle(1);
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (debug_req !== 1'b1 && waited < `SOC_DBG_HOLDOFF + 10);
    if (debug_req !== 1'b1) begin
      report_failure("debug request never rose after the hold-off");
    end else begin
      check_value("debug request rise edge", `SOC_DBG_HOLDOFF + 1, cyc);
    end
    issue(1'b0, `SOC_DEBUG_BASE + 32'h8, '0, '0);
    debug_en <= 1'b0;
    idle(3);
    debug_en <= 1'b1;
    idle(3);
    issue(1'b1, `SOC_DEBUG_BASE, 4'hf, 32'h0);
    finish_test();

    begin_test("rom_image");
    for (int i = 0; i < `SOC_ROM_WORDS; i++) begin
      issue(1'b0, `SOC_ROM_BASE + addr_t'(4 * i), '0, '0);
    end
    issue(1'b1, `SOC_ROM_BASE + 32'hc, 4'hf, next_random());
    issue(1'b0, `SOC_ROM_BASE + 32'hc, '0, '0);
    finish_test();

    begin_test("ram_random");
    for (int i = 0; i < n_ram_init; i++) begin
      r = next_random();
      issue(1'b1, ram_slot_addr(i, r[31:30]), 4'hf, next_random());
    end
    for (int i = 0; i < n_ram_rand; i++) begin
      r = next_random();
      issue(1'b1, ram_slot_addr(r[28:24], r[31:30]), r[23:20], next_random());
    end
    for (int i = 0; i < n_ram_init; i++) begin
      r = next_random();
      issue(1'b0, ram_slot_addr(i, r[31:30]), '0, '0);
    end
    finish_test();

    begin_test("unmapped");
    for (int i = 0; i < n_unmapped; i++) begin
      issue(1'b0, unmapped_addrs[i], '0, '0);
      issue(1'b1, unmapped_addrs[i], 4'hf, next_random());
    end
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== soc_params.svh ====
// region bases must be aligned to their lengths and regions must not overlap
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_BE_W   4

// address map, base and length in bytes
`define SOC_DEBUG_BASE 32'h0000_0000
`define SOC_DEBUG_LEN  32'h0000_0100
`define SOC_ROM_BASE   32'h0001_0000
`define SOC_ROM_LEN    32'h0000_0040
`define SOC_RAM_BASE   32'h8000_0000
`define SOC_RAM_LEN    32'h0000_0400

// memory sizes in words
`define SOC_ROM_WORDS 16
`define SOC_RAM_WORDS 256

// cycles after reset before a debug request may reach the core
`define SOC_DBG_HOLDOFF 20

`endif

// ==== soc_pkg.sv ====
// bus types assume a 32-bit word with 4 byte lanes; address bits 1:0 carry no meaning
`include "soc_params.svh"

package soc_pkg;

  // --------------------------------------------------
  // basic bus fields
  // --------------------------------------------------
  typedef logic [`SOC_ADDR_W-1:0]            addr_t;
  typedef logic [`SOC_DATA_W-1:0]            data_t;
  typedef logic [`SOC_BE_W-1:0]              be_t;
  typedef logic [$clog2(`SOC_ROM_WORDS)-1:0] rom_idx_t;
  typedef logic [$clog2(`SOC_RAM_WORDS)-1:0] ram_idx_t;

  // single-beat request, no handshake
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
  } mem_req_t;

  // response, one cycle after the request
  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    REGION_DEBUG,
    REGION_ROM,
    REGION_RAM,
    REGION_NONE
  } region_e;

  // debug register word offsets
  typedef enum logic [1:0] {
    DBG_CTRL   = 2'd0,
    DBG_EXIT   = 2'd1,
    DBG_STATUS = 2'd2
  } dbg_reg_e;

endpackage

// ==== sources.f ====
+incdir+.
soc_pkg.sv
bus_router.sv
boot_rom.sv
main_sram.sv
debug_unit.sv
soc_harness.sv
soc_harness_chk.sv
soc_harness_tb.sv
